// ==== verilog/cache_pkg.sv ====
package cache_pkg;

    // cpu word and line geometry
    localparam int word_bits      = 16;
    localparam int words_per_line = 4;
    localparam int line_bits      = word_bits * words_per_line;

    // address splits into tag, index and offset from the top down
    localparam int offset_bits = 2;
    localparam int index_bits  = 1;
    localparam int num_sets    = 2;
    localparam int tag_bits    = 13;

    // tag entry holds the tag in the low bits and the state flags on top
    localparam int tag_entry_bits   = 16;
    localparam int entry_valid_bit  = 15;
    localparam int entry_dirty_bit  = 14;
    localparam int entry_recent_bit = 13;

    // controller states
    localparam logic [1:0] state_check      = 2'b00;
    localparam logic [1:0] state_allocate   = 2'b01;
    localparam logic [1:0] state_write_back = 2'b10;

    // cpu address seen either as one word or as its cache fields
    typedef union packed {
        logic [word_bits-1:0] word;
        struct packed {
            logic [tag_bits-1:0]    tag;
            logic [index_bits-1:0]  index;
            logic [offset_bits-1:0] offset;
        } fields;
    } cache_addr_u;

endpackage

// ==== verilog/line_store_if.sv ====
`timescale 1ns/1ps

interface line_store_if
    import cache_pkg::*;
();

    // set being accessed and write strobe for both ways
    logic [index_bits-1:0] index;
    logic                  we;

    // per-way values of the indexed set
    logic [1:0][tag_entry_bits-1:0] tag_rd;
    logic [1:0][line_bits-1:0]      line_rd;

    // per-way values to store at the clock edge
    logic [1:0][tag_entry_bits-1:0] tag_wr;
    logic [1:0][line_bits-1:0]      line_wr;

    modport ctrl (
        output index, we, tag_wr, line_wr,
        input  tag_rd, line_rd
    );

    modport store (
        input  index, we, tag_wr, line_wr,
        output tag_rd, line_rd
    );

    modport view (
        input tag_rd, line_rd
    );

endinterface

// ==== verilog/line_store.sv ====
`timescale 1ns/1ps

module line_store
    import cache_pkg::*;
(
    input logic        clk,
    input logic        reset_n,
    line_store_if.store port
);

    // tag entries and line data, indexed by set then way
    logic [tag_entry_bits-1:0] tag_mem  [num_sets][2];
    logic [line_bits-1:0]      line_mem [num_sets][2];

    // combinational read of the indexed set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            port.tag_rd[w]  = tag_mem[port.index][w];
            port.line_rd[w] = line_mem[port.index][w];
        end
    end

    // tag entries start out invalid, clean and not recent
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < 2; w++) begin
                    tag_mem[s][w] <= '0;
                end
            end
        end else if (port.we) begin
            for (int w = 0; w < 2; w++) begin
                tag_mem[port.index][w] <= port.tag_wr[w];
            end
        end
    end

    // both ways of the set take their line data together
    always_ff @(posedge clk) begin
        if (port.we) begin
            for (int w = 0; w < 2; w++) begin
                line_mem[port.index][w] <= port.line_wr[w];
            end
        end
    end

endmodule

// ==== verilog/way_select.sv ====
`timescale 1ns/1ps

module way_select
    import cache_pkg::*;
(
    line_store_if.view           port,
    input  cache_addr_u          addr,
    input  logic [word_bits-1:0] wdata,
    input  logic [line_bits-1:0] fill_line,
    input  logic                 use_fill,
    output logic                 hit,
    output logic                 hit_way,
    output logic                 victim_way,
    output logic                 victim_dirty,
    output logic [tag_bits-1:0]  victim_tag,
    output logic [word_bits-1:0] rd_word,
    output logic [line_bits-1:0] merged_line
);

    logic [1:0]             way_hit;
    logic [line_bits-1:0]   src_line;
    logic [offset_bits-1:0] slot;

    // tag match on a valid way
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = port.tag_rd[w][entry_valid_bit] &&
                         (port.tag_rd[w][tag_bits-1:0] == addr.fields.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // way 1 is evicted only when way 0 holds the recent bit
    // so a set with no recent bits falls back to way 0
    assign victim_way   = port.tag_rd[0][entry_recent_bit];
    assign victim_dirty = port.tag_rd[victim_way][entry_valid_bit] &&
                          port.tag_rd[victim_way][entry_dirty_bit];
    assign victim_tag   = port.tag_rd[victim_way][tag_bits-1:0];

    // word 0 sits in the top bits of the line
    assign slot     = offset_bits'(words_per_line - 1) - addr.fields.offset;
    assign src_line = use_fill ? fill_line : port.line_rd[hit_way];
    assign rd_word  = src_line[slot*word_bits +: word_bits];

    always_comb begin
        merged_line = src_line;
        merged_line[slot*word_bits +: word_bits] = wdata;
    end

endmodule

// ==== verilog/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    line_store_if.ctrl           port,
    input  cache_addr_u          addr,
    input  logic                 cpu_valid,
    input  logic                 cpu_read,
    input  logic                 cpu_write,
    input  logic                 hit,
    input  logic                 hit_way,
    input  logic                 victim_way,
    input  logic                 victim_dirty,
    input  logic [tag_bits-1:0]  victim_tag,
    input  logic [line_bits-1:0] merged_line,
    input  logic [line_bits-1:0] mem_rdata,
    input  logic                 mem_ready,
    input  logic                 mem_ack,
    output logic                 use_fill,
    output logic                 cpu_read_ready,
    output logic                 cpu_write_ack,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [word_bits-1:0] mem_addr,
    output logic [line_bits-1:0] mem_wdata
);

    logic [1:0] state;
    logic [1:0] next_state;
    logic       fill_way;
    logic       request;

    assign request = cpu_valid && (cpu_read || cpu_write);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= state_check;
            fill_way <= 1'b0;
        end else begin
            state <= next_state;
            // way to refill is fixed at the miss
            if (state == state_check && request && !hit) begin
                fill_way <= victim_way;
            end
        end
    end

    // memory side follows the state directly
    assign mem_write = (state == state_write_back);
    assign mem_read  = (state == state_allocate);
    assign use_fill  = (state == state_allocate);
    assign mem_wdata = port.line_rd[fill_way];

    // arrays stay untouched during a miss, so victim_tag still names fill_way
    always_comb begin
        if (state == state_write_back) begin
            mem_addr = {victim_tag, addr.fields.index, {offset_bits{1'b0}}};
        end else begin
            mem_addr = {addr.fields.tag, addr.fields.index, {offset_bits{1'b0}}};
        end
    end

    always_comb begin
        next_state     = state;
        cpu_read_ready = 1'b0;
        cpu_write_ack  = 1'b0;
        port.index     = addr.fields.index;
        port.we        = 1'b0;
        // unchanged entries are written back as read
        port.tag_wr    = port.tag_rd;
        port.line_wr   = port.line_rd;

        case (state)
            state_check: begin
                if (request && hit) begin
                    port.we = 1'b1;
                    port.tag_wr[hit_way][entry_recent_bit]  = 1'b1;
                    port.tag_wr[~hit_way][entry_recent_bit] = 1'b0;
                    if (cpu_write) begin
                        port.tag_wr[hit_way][entry_dirty_bit] = 1'b1;
                        port.line_wr[hit_way] = merged_line;
                        cpu_write_ack = 1'b1;
                    end else begin
                        cpu_read_ready = 1'b1;
                    end
                end else if (request) begin
                    next_state = victim_dirty ? state_write_back : state_allocate;
                end
            end

            state_write_back: begin
                if (mem_ack) begin
                    next_state = state_allocate;
                end
            end

            state_allocate: begin
                if (mem_ready) begin
                    port.we = 1'b1;
                    port.tag_wr[fill_way] = '0;
                    port.tag_wr[fill_way][tag_bits-1:0]     = addr.fields.tag;
                    port.tag_wr[fill_way][entry_valid_bit]  = 1'b1;
                    port.tag_wr[fill_way][entry_recent_bit] = 1'b1;
                    port.tag_wr[fill_way][entry_dirty_bit]  = cpu_write;
                    port.tag_wr[~fill_way][entry_recent_bit] = 1'b0;
                    // a write miss installs the refill with its word merged in
                    port.line_wr[fill_way] = cpu_write ? merged_line : mem_rdata;
                    cpu_write_ack  = cpu_write;
                    cpu_read_ready = !cpu_write;
                    next_state     = state_check;
                end
            end

            default: begin
                next_state = state_check;
            end
        endcase
    end

endmodule

// ==== verilog/data_cache.sv ====
`timescale 1ns/1ps

module data_cache
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 cpu_valid,
    input  logic                 cpu_read,
    input  logic                 cpu_write,
    input  logic [word_bits-1:0] cpu_addr,
    input  logic [word_bits-1:0] cpu_wdata,
    output logic [word_bits-1:0] cpu_rdata,
    output logic                 cpu_read_ready,
    output logic                 cpu_write_ack,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic [word_bits-1:0] mem_addr,
    output logic [line_bits-1:0] mem_wdata,
    input  logic [line_bits-1:0] mem_rdata,
    input  logic                 mem_ready,
    input  logic                 mem_ack
);

    logic                 hit;
    logic                 hit_way;
    logic                 victim_way;
    logic                 victim_dirty;
    logic [tag_bits-1:0]  victim_tag;
    logic [line_bits-1:0] merged_line;
    logic                 use_fill;

    line_store_if store_if ();

    line_store store_i (
        .clk     (clk),
        .reset_n (reset_n),
        .port    (store_if.store)
    );

    // refill data doubles as the fill source for word select and merge
    way_select select_i (
        .port         (store_if.view),
        .addr         (cpu_addr),
        .wdata        (cpu_wdata),
        .fill_line    (mem_rdata),
        .use_fill     (use_fill),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .rd_word      (cpu_rdata),
        .merged_line  (merged_line)
    );

    cache_ctrl ctrl_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .port           (store_if.ctrl),
        .addr           (cpu_addr),
        .cpu_valid      (cpu_valid),
        .cpu_read       (cpu_read),
        .cpu_write      (cpu_write),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .victim_tag     (victim_tag),
        .merged_line    (merged_line),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .mem_ack        (mem_ack),
        .use_fill       (use_fill),
        .cpu_read_ready (cpu_read_ready),
        .cpu_write_ack  (cpu_write_ack),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata)
    );

endmodule

// ==== testbench/data_cache_asserts.sv ====
`timescale 1ns/1ps

module data_cache_asserts
    import cache_pkg::*;
(
    input logic                 clk,
    input logic                 reset_n,
    input logic                 cpu_valid,
    input logic                 cpu_read_ready,
    input logic                 cpu_write_ack,
    input logic                 mem_read,
    input logic                 mem_write,
    input logic [word_bits-1:0] mem_addr
);

    // the single memory port carries one request type at a time
    mem_one_request: assert property (
        @(posedge clk) disable iff (!reset_n) !(mem_read && mem_write)
    ) else $error("mem_read and mem_write are high together");

    strobe_needs_request: assert property (
        @(posedge clk) disable iff (!reset_n)
        (cpu_read_ready || cpu_write_ack) |-> cpu_valid
    ) else $error("response strobe while cpu_valid is low");

    // memory traffic moves whole lines
    mem_addr_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        (mem_read || mem_write) |-> (mem_addr[offset_bits-1:0] == '0)
    ) else $error("mem_addr %h is not line aligned", mem_addr);

endmodule

bind data_cache data_cache_asserts asserts_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .cpu_valid      (cpu_valid),
    .cpu_read_ready (cpu_read_ready),
    .cpu_write_ack  (cpu_write_ack),
    .mem_read       (mem_read),
    .mem_write      (mem_write),
    .mem_addr       (mem_addr)
);

// ==== testbench/tb_data_cache.sv ====
`timescale 1ns/1ps

module tb_data_cache
    import cache_pkg::*;
();

    localparam int reset_cycles    = 16;
    localparam int cycles_per_case = 40;
    localparam int max_cases       = 64;

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 cpu_valid;
    logic                 cpu_read;
    logic                 cpu_write;
    logic [word_bits-1:0] cpu_addr;
    logic [word_bits-1:0] cpu_wdata;
    logic [word_bits-1:0] cpu_rdata;
    logic                 cpu_read_ready;
    logic                 cpu_write_ack;
    logic                 mem_read;
    logic                 mem_write;
    logic [word_bits-1:0] mem_addr;
    logic [line_bits-1:0] mem_wdata;
    logic [line_bits-1:0] mem_rdata;
    logic                 mem_ready;
    logic                 mem_ack;

    // cases as read from the cases file
    string                case_name  [max_cases];
    logic                 case_write [max_cases];
    cache_addr_u          case_addr  [max_cases];
    logic [word_bits-1:0] case_wdata [max_cases];
    logic [word_bits-1:0] case_rdata [max_cases];
    logic                 case_miss  [max_cases];
    logic                 case_wb    [max_cases];
    int                   num_cases;

    // memory model state
    logic [word_bits-1:0] mem_words [65536];
    logic [line_bits-1:0] fill_line;
    logic [31:0]          rng_state;
    logic [1:0]           wait_left;
    logic                 busy;
    int                   refill_total = 0;
    int                   write_back_total = 0;

    int cycle_count = 0;
    int cycle_limit;

    data_cache dut_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .cpu_valid      (cpu_valid),
        .cpu_read       (cpu_read),
        .cpu_write      (cpu_write),
        .cpu_addr       (cpu_addr),
        .cpu_wdata      (cpu_wdata),
        .cpu_rdata      (cpu_rdata),
        .cpu_read_ready (cpu_read_ready),
        .cpu_write_ack  (cpu_write_ack),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_addr       (mem_addr),
        .mem_wdata      (mem_wdata),
        .mem_rdata      (mem_rdata),
        .mem_ready      (mem_ready),
        .mem_ack        (mem_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input logic [word_bits-1:0] expected,
                              input logic [word_bits-1:0] actual);
        if (actual !== expected) begin
            $display("ERROR %s read data: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input string what,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s %s: expected %b, actual %b", name, what, expected, actual);
            abort_run();
        end
    endtask

    // memory answers one line request after 1 to 4 cycles
    // line word 0 sits in the top bits
    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem_words[i] = i[15:0] ^ 16'ha5a5;
        end
        rng_state = 32'h2ce3;
        busy      = 1'b0;
        wait_left = 2'd0;
        mem_ready <= 1'b0;
        mem_ack   <= 1'b0;
        mem_rdata <= '0;
        forever begin
            @(posedge clk);
            mem_ready <= 1'b0;
            mem_ack   <= 1'b0;
            if (reset_n && (mem_read || mem_write) && !mem_ready && !mem_ack) begin
                if (!busy) begin
                    rng_state = xorshift32(rng_state);
                    wait_left = rng_state[1:0];
                    busy      = 1'b1;
                end else if (wait_left != 2'd0) begin
                    wait_left = wait_left - 2'd1;
                end else if (mem_write) begin
                    for (int w = 0; w < words_per_line; w++) begin
                        mem_words[mem_addr + 16'(w)] =
                            mem_wdata[(words_per_line - 1 - w) * word_bits +: word_bits];
                    end
                    mem_ack <= 1'b1;
                    write_back_total = write_back_total + 1;
                    busy = 1'b0;
                end else begin
                    for (int w = 0; w < words_per_line; w++) begin
                        fill_line[(words_per_line - 1 - w) * word_bits +: word_bits] =
                            mem_words[mem_addr + 16'(w)];
                    end
                    mem_rdata <= fill_line;
                    mem_ready <= 1'b1;
                    refill_total = refill_total + 1;
                    busy = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the cache gave no response within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    task automatic load_cases();
        int                   fd;
        int                   fields;
        int                   miss_in;
        int                   wb_in;
        string                line;
        string                name;
        string                op;
        logic [word_bits-1:0] addr_in;
        logic [word_bits-1:0] wdata_in;
        logic [word_bits-1:0] rdata_in;
        num_cases = 0;
        fd = $fopen("testbench/cache_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/cache_cases.txt");
            abort_run();
        end else begin
            while (!$feof(fd) && num_cases < max_cases) begin
                line = "";
                void'($fgets(line, fd));
                // blank lines and comments carry no case
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                fields = $sscanf(line, "%s %s %h %h %h %d %d", name, op,
                                 addr_in, wdata_in, rdata_in, miss_in, wb_in);
                if (fields != 7) begin
                    $display("cases file line cannot be parsed: %s", line);
                    abort_run();
                end else begin
                    case_name[num_cases]      = name;
                    case_write[num_cases]     = (op == "W");
                    case_addr[num_cases].word = addr_in;
                    case_wdata[num_cases]     = wdata_in;
                    case_rdata[num_cases]     = rdata_in;
                    case_miss[num_cases]      = (miss_in != 0);
                    case_wb[num_cases]        = (wb_in != 0);
                    num_cases = num_cases + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_case(input int n);
        int                   refills_before;
        int                   write_backs_before;
        logic                 got_read;
        logic                 got_write;
        logic [word_bits-1:0] rdata_seen;
        @(posedge clk);
        refills_before     = refill_total;
        write_backs_before = write_back_total;
        cpu_valid <= 1'b1;
        cpu_read  <= !case_write[n];
        cpu_write <= case_write[n];
        cpu_addr  <= case_addr[n].word;
        cpu_wdata <= case_wdata[n];
        // strobes are sampled between edges and the request drops at the next edge
        do begin
            @(negedge clk);
            got_read  = cpu_read_ready;
            got_write = cpu_write_ack;
        end while (!got_read && !got_write);
        rdata_seen = cpu_rdata;
        @(posedge clk);
        cpu_valid <= 1'b0;
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
        if (got_write != case_write[n] || got_read != !case_write[n]) begin
            $display("case %s finished with the wrong response strobe", case_name[n]);
            abort_run();
        end else begin
            if (!case_write[n]) begin
                check_word(case_name[n], case_rdata[n], rdata_seen);
            end
            check_flag(case_name[n], "miss flag", case_miss[n],
                       refill_total != refills_before);
            check_flag(case_name[n], "write-back flag", case_wb[n],
                       write_back_total != write_backs_before);
        end
    endtask

    initial begin
        reset_n   <= 1'b0;
        cpu_valid <= 1'b0;
        cpu_read  <= 1'b0;
        cpu_write <= 1'b0;
        cpu_addr  <= '0;
        cpu_wdata <= '0;
        cycle_limit = reset_cycles + cycles_per_case;
        load_cases();
        cycle_limit = reset_cycles + cycles_per_case * num_cases;
        repeat (reset_cycles) @(posedge clk);
        reset_n <= 1'b1;
        for (int n = 0; n < num_cases; n++) begin
            run_case(n);
        end
        if (num_cases == 0) begin
            $display("the cases file holds no cases");
            abort_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// ==== testbench/cache_cases.txt ====
# name op addr wdata rdata miss write_back
# op is R or W, addr wdata rdata in hex, rdata not checked for writes
cold_read_a0    R 0010 0000 a5b5 1 0
hit_read_a1     R 0011 0000 a5b4 0 0
hit_read_a2     R 0012 0000 a5b7 0 0
hit_read_a3     R 0013 0000 a5b6 0 0
write_hit_a2    W 0012 1234 0000 0 0
read_back_a2    R 0012 0000 1234 0 0
lru_fill_a      R 0024 0000 a581 1 0
lru_fill_b      R 0045 0000 a5e0 1 0
lru_touch_a     R 0026 0000 a583 0 0
lru_fill_c      R 0066 0000 a5c3 1 0
lru_keep_a      R 0025 0000 a580 0 0
lru_lost_b      R 0047 0000 a5e2 1 0
evict_fill_x    R 0030 0000 a595 1 0
evict_dirty_a   R 0050 0000 a5f5 1 1
refetch_a2      R 0012 0000 1234 1 0
write_miss_d0   W 0084 beef 0000 1 0
merge_keep_d1   R 0085 0000 a520 0 0
merge_word_d0   R 0084 0000 beef 0 0
fill_set1_e     R 00a4 0000 a501 1 0
evict_dirty_d   R 00c4 0000 a561 1 1
refill_d2       R 0086 0000 a523 1 0
refetch_d0      R 0084 0000 beef 0 0

// ==== tb.f ====
verilog/cache_pkg.sv
verilog/line_store_if.sv
verilog/line_store.sv
verilog/way_select.sv
verilog/cache_ctrl.sv
verilog/data_cache.sv
testbench/data_cache_asserts.sv
testbench/tb_data_cache.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert -j 0 --top-module tb_data_cache -f tb.f -o sim_data_cache
	-./obj_dir/sim_data_cache > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
